/* hdl/fpu_defines.svh */
// fpu defines: widths, format codes, operation codes and canonical NaNs of the misc FPU
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// widths
`define FPU_XLEN    64
`define FPU_RFIDX_W 5
`define FPU_FTYPE_W 5
`define FPU_FLAGS_W 5

// fmt field
`define FPU_FMT_S 2'b00
`define FPU_FMT_D 2'b11

// ftype codes, same numbering as the full arithmetic unit
`define FPU_OP_FMIN      5'd3
`define FPU_OP_FMAX      5'd4
`define FPU_OP_FSGNJ     5'd17
`define FPU_OP_FSGNJN    5'd18
`define FPU_OP_FSGNJX    5'd19
`define FPU_OP_FEQ       5'd20
`define FPU_OP_FLT       5'd21
`define FPU_OP_FLE       5'd22
`define FPU_OP_FCLASS    5'd23
`define FPU_OP_FMV_TO_F  5'd24 // fmv.w.x / fmv.d.x
`define FPU_OP_FMV_TO_X  5'd25 // fmv.x.w / fmv.x.d

// canonical quiet NaNs
`define FPU_QNAN_S 32'h7fc00000
`define FPU_QNAN_D 64'h7ff8000000000000

`endif

/* hdl/fpu_pkg.sv */
// fpu package: request, response, flag, class and compare types of the misc FPU
`include "fpu_defines.svh"

package fpu_pkg;

	// double view of a register word
	typedef struct packed {
		logic        sign;
		logic [10:0] exp;
		logic [51:0] frac;
	} fp_dbl_t;

	// single view, upper half carries no meaning for the value
	typedef struct packed {
		logic [`FPU_XLEN-33:0] upper;
		logic                  sign;
		logic [7:0]            exp;
		logic [22:0]           frac;
	} fp_sgl_t;

	typedef union packed {
		fp_dbl_t d;
		fp_sgl_t s;
	} fp_word_u;

	typedef struct packed {
		logic invalid;
		logic infinite;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpu_flags_t;

	typedef struct packed {
		logic [`FPU_FTYPE_W-1:0] ftype;
		logic [1:0]              fmt;
		fp_word_u                frs1;
		fp_word_u                frs2;
		logic [`FPU_RFIDX_W-1:0] rd_idx;
	} fpu_req_t;

	typedef struct packed {
		fp_word_u                result;
		fpu_flags_t              exception_flags;
		logic                    fflags_valid;
		logic [`FPU_RFIDX_W-1:0] rd_idx;
	} fpu_resp_t;

	// exactly one of the is_* bits is set
	typedef struct packed {
		logic sign;
		logic is_zero;
		logic is_subnormal;
		logic is_normal;
		logic is_inf;
		logic is_snan;
		logic is_qnan;
	} fp_class_t;

	typedef struct packed {
		logic lt;             // a < b, ordered only
		logic eq;             // a == b, ordered only
		logic unordered;      // any NaN
		logic invalid_quiet;  // any sNaN, for feq/fmin/fmax
		logic invalid_signal; // any NaN, for flt/fle
		logic min_sel_b;
		logic max_sel_b;
	} fp_cmp_t;

endpackage

/* hdl/fp_classify.sv */
// fp classifier: sorts one operand into its IEEE class for single or double format
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fp_classify (
	input  logic [1:0]          fmt,
	input  fpu_pkg::fp_word_u   operand,
	output fpu_pkg::fp_class_t  cls
);

	logic sign;
	logic exp_max;   // exponent all ones
	logic exp_zero;
	logic frac_zero;
	logic quiet_bit; // top fraction bit

	// field extraction per format
	always_comb begin
		if (fmt == `FPU_FMT_S) begin
			sign      = operand.s.sign;
			exp_max   = &operand.s.exp;
			exp_zero  = ~|operand.s.exp;
			frac_zero = ~|operand.s.frac;
			quiet_bit = operand.s.frac[22];
		end else begin
			// double view, also for unsupported fmt (dropped later)
			sign      = operand.d.sign;
			exp_max   = &operand.d.exp;
			exp_zero  = ~|operand.d.exp;
			frac_zero = ~|operand.d.frac;
			quiet_bit = operand.d.frac[51];
		end
	end

	// one-hot class
	always_comb begin
		cls              = '0;
		cls.sign         = sign;
		if (exp_zero) begin
			if (frac_zero)
				cls.is_zero = 1'b1;
			else
				cls.is_subnormal = 1'b1;
		end else if (exp_max) begin
			if (frac_zero)
				cls.is_inf = 1'b1;
			else if (quiet_bit)
				cls.is_qnan = 1'b1;
			else
				cls.is_snan = 1'b1; // msb clear, rest nonzero
		end else begin
			cls.is_normal = 1'b1;
		end
	end

endmodule

/* hdl/fp_compare.sv */
// fp comparator: orders two operands, picks min/max side and derives the invalid conditions
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fp_compare (
	input  logic [1:0]          fmt,
	input  fpu_pkg::fp_word_u   frs1,
	input  fpu_pkg::fp_word_u   frs2,
	input  fpu_pkg::fp_class_t  cls_a,
	input  fpu_pkg::fp_class_t  cls_b,
	output fpu_pkg::fp_cmp_t    cmp
);

	logic [62:0] mag_a; // exponent and fraction as one unsigned value
	logic [62:0] mag_b;
	logic        nan_a;
	logic        nan_b;
	logic        unordered;
	logic        both_zero;
	logic        ord_lt;
	logic        ord_eq;
	logic        ord_gt;

	// magnitudes, single right-aligned
	always_comb begin
		if (fmt == `FPU_FMT_S) begin
			mag_a = {32'b0, frs1.s.exp, frs1.s.frac};
			mag_b = {32'b0, frs2.s.exp, frs2.s.frac};
		end else begin
			mag_a = {frs1.d.exp, frs1.d.frac};
			mag_b = {frs2.d.exp, frs2.d.frac};
		end
	end

	assign nan_a     = cls_a.is_snan | cls_a.is_qnan;
	assign nan_b     = cls_b.is_snan | cls_b.is_qnan;
	assign unordered = nan_a | nan_b;
	assign both_zero = cls_a.is_zero & cls_b.is_zero;

	// ordering of two non-NaN values
	always_comb begin
		ord_lt = 1'b0;
		ord_eq = 1'b0;
		if (unordered) begin
			ord_lt = 1'b0; // NaN compares false
			ord_eq = 1'b0;
		end else if (both_zero) begin
			ord_eq = 1'b1; // +0 == -0
		end else if (cls_a.sign != cls_b.sign) begin
			ord_lt = cls_a.sign;
		end else if (!cls_a.sign) begin
			ord_lt = mag_a < mag_b;
			ord_eq = mag_a == mag_b;
		end else begin
			// both negative, larger magnitude is smaller
			ord_lt = mag_a > mag_b;
			ord_eq = mag_a == mag_b;
		end
	end

	assign ord_gt = ~ord_lt & ~ord_eq & ~unordered;

	always_comb begin
		cmp                = '0;
		cmp.lt             = ord_lt;
		cmp.eq             = ord_eq;
		cmp.unordered      = unordered;
		cmp.invalid_quiet  = cls_a.is_snan | cls_b.is_snan;
		cmp.invalid_signal = unordered;

		// b wins when a is the lone NaN or b lies on the wanted side
		cmp.min_sel_b = (nan_a & ~nan_b) |
			(~unordered & (ord_gt | (both_zero & cls_b.sign & ~cls_a.sign)));
		cmp.max_sel_b = (nan_a & ~nan_b) |
			(~unordered & (ord_lt | (both_zero & cls_a.sign & ~cls_b.sign)));
	end

endmodule

/* hdl/fp_result_select.sv */
// result selector: builds the per-ftype result and flags, then registers the response
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fp_result_select (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	input  fpu_pkg::fpu_req_t   req,
	input  fpu_pkg::fp_class_t  cls_a,
	input  fpu_pkg::fp_class_t  cls_b,
	input  fpu_pkg::fp_cmp_t    cmp,
	output logic                out_valid,
	output fpu_pkg::fpu_resp_t  resp
);

	logic                is_s;
	logic                fmt_ok;
	logic                both_nan;
	logic                pick_b;
	logic                inj_sign;
	logic [9:0]          class_mask;
	logic [`FPU_XLEN-1:0] res;
	fpu_pkg::fpu_flags_t flags;
	logic                flags_vld;
	fpu_pkg::fpu_resp_t  resp_nxt;

	// single results sit zero-extended in the low half
	function automatic logic [`FPU_XLEN-1:0] fit_word(input fpu_pkg::fp_word_u w,
		input logic single);
		fit_word = single ? {32'b0, w[31:0]} : w;
	endfunction

	assign is_s     = req.fmt == `FPU_FMT_S;
	assign fmt_ok   = is_s | (req.fmt == `FPU_FMT_D);
	assign both_nan = cmp.unordered & (cls_a.is_snan | cls_a.is_qnan) &
		(cls_b.is_snan | cls_b.is_qnan);
	assign pick_b   = (req.ftype == `FPU_OP_FMIN) ? cmp.min_sel_b : cmp.max_sel_b;

	always_comb begin
		case (req.ftype)
			`FPU_OP_FSGNJN: inj_sign = ~cls_b.sign;
			`FPU_OP_FSGNJX: inj_sign = cls_a.sign ^ cls_b.sign;
			default:        inj_sign = cls_b.sign;
		endcase
	end

	// fclass: -inf .. +inf, then sNaN, qNaN
	assign class_mask = {cls_a.is_qnan, cls_a.is_snan,
		~cls_a.sign & cls_a.is_inf, ~cls_a.sign & cls_a.is_normal,
		~cls_a.sign & cls_a.is_subnormal, ~cls_a.sign & cls_a.is_zero,
		cls_a.sign & cls_a.is_zero, cls_a.sign & cls_a.is_subnormal,
		cls_a.sign & cls_a.is_normal, cls_a.sign & cls_a.is_inf};

	always_comb begin
		res       = '0;
		flags     = '0;
		flags_vld = 1'b0;
		if (fmt_ok) begin
			case (req.ftype)
				`FPU_OP_FMIN, `FPU_OP_FMAX: begin
					flags_vld     = 1'b1;
					flags.invalid = cmp.invalid_quiet;
					if (both_nan)
						res = is_s ? {32'b0, `FPU_QNAN_S} : `FPU_QNAN_D;
					else
						res = fit_word(pick_b ? req.frs2 : req.frs1, is_s);
				end
				`FPU_OP_FSGNJ, `FPU_OP_FSGNJN, `FPU_OP_FSGNJX: begin
					if (is_s)
						res = {32'b0, inj_sign, req.frs1.s.exp, req.frs1.s.frac};
					else
						res = {inj_sign, req.frs1.d.exp, req.frs1.d.frac};
				end
				`FPU_OP_FEQ: begin
					flags_vld     = 1'b1;
					flags.invalid = cmp.invalid_quiet; // quiet compare
					res           = {63'b0, cmp.eq};
				end
				`FPU_OP_FLT: begin
					flags_vld     = 1'b1;
					flags.invalid = cmp.invalid_signal;
					res           = {63'b0, cmp.lt};
				end
				`FPU_OP_FLE: begin
					flags_vld     = 1'b1;
					flags.invalid = cmp.invalid_signal;
					res           = {63'b0, cmp.lt | cmp.eq};
				end
				`FPU_OP_FCLASS:   res = {54'b0, class_mask};
				`FPU_OP_FMV_TO_F: res = fit_word(req.frs1, is_s);
				`FPU_OP_FMV_TO_X: begin
					if (is_s)
						res = {{32{req.frs1.s.sign}}, req.frs1[31:0]}; // sign-extend to xlen
					else
						res = req.frs1;
				end
				default: res = '0; // unused code
			endcase
		end
	end

	always_comb begin
		resp_nxt                 = '0;
		resp_nxt.result          = res;
		resp_nxt.exception_flags = flags;
		resp_nxt.fflags_valid    = flags_vld;
		resp_nxt.rd_idx          = req.rd_idx;
	end

	// output stage, holds until the next accepted request
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			resp      <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid)
				resp <= resp_nxt;
		end
	end

endmodule

/* hdl/fpu_misc_unit.sv */
// misc fpu top: min/max, sign injection, compares, fclass and moves with one cycle latency
`timescale 1ns/100ps

module fpu_misc_unit (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	input  fpu_pkg::fpu_req_t  req,
	output logic               out_valid,
	output fpu_pkg::fpu_resp_t resp
);

	fpu_pkg::fp_class_t cls_a; // class of frs1
	fpu_pkg::fp_class_t cls_b; // class of frs2
	fpu_pkg::fp_cmp_t   cmp;

	// operand classifiers
	fp_classify u_cls_a (
		.fmt     (req.fmt),
		.operand (req.frs1),
		.cls     (cls_a)
	);

	fp_classify u_cls_b (
		.fmt     (req.fmt),
		.operand (req.frs2),
		.cls     (cls_b)
	);

	// ordering and min/max side
	fp_compare u_cmp (
		.fmt   (req.fmt),
		.frs1  (req.frs1),
		.frs2  (req.frs2),
		.cls_a (cls_a),
		.cls_b (cls_b),
		.cmp   (cmp)
	);

	// result mux and output register
	fp_result_select u_sel (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.req       (req),
		.cls_a     (cls_a),
		.cls_b     (cls_b),
		.cmp       (cmp),
		.out_valid (out_valid),
		.resp      (resp)
	);

endmodule

/* tb/fpu_misc_asserts.sv */
// misc fpu assertions: strobe timing, flag usage and fclass encoding at the top-level ports
`timescale 1ns/100ps
`include "fpu_defines.svh"

module fpu_misc_asserts (
	input logic               clk,
	input logic               arst_n,
	input logic               in_valid,
	input fpu_pkg::fpu_req_t  req,
	input logic               out_valid,
	input fpu_pkg::fpu_resp_t resp
);

	logic fclass_seen; // fclass with a supported fmt taken at the last edge

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			fclass_seen <= 1'b0;
		else
			fclass_seen <= in_valid && req.ftype == `FPU_OP_FCLASS &&
				(req.fmt == `FPU_FMT_S || req.fmt == `FPU_FMT_D);
	end

	a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid))
		else $error("out_valid is not in_valid delayed by one cycle");

	a_only_invalid: assert property (@(posedge clk) disable iff (!arst_n)
		resp.exception_flags[3:0] == 4'b0)
		else $error("flag other than invalid is set");

	// fflags_valid can only come up with a fresh response
	a_fflags_new: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(resp.fflags_valid) |-> out_valid)
		else $error("fflags_valid rose without out_valid");

	a_fclass_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && fclass_seen |-> $onehot(resp.result[9:0]) && resp.result[63:10] == 54'b0)
		else $error("fclass result is not one-hot");

endmodule

bind fpu_misc_unit fpu_misc_asserts u_asserts (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.req       (req),
	.out_valid (out_valid),
	.resp      (resp)
);

/* tb/tb_fpu_misc_unit.sv */
// misc fpu testbench driving LFSR requests and checking them against a reference model
`timescale 1ns/100ps
`include "fpu_defines.svh"

module tb_fpu_misc_unit;

	localparam int NUM_REQ      = 3000;
	localparam int RESET_CYCLES = 3;
	localparam int MAX_CYCLES   = 2 * NUM_REQ + RESET_CYCLES + 20; // at most one idle per request

	// kept codes then unused ones
	localparam logic [4:0] FTYPE_TBL [16] = '{`FPU_OP_FMIN, `FPU_OP_FMAX, `FPU_OP_FSGNJ,
		`FPU_OP_FSGNJN, `FPU_OP_FSGNJX, `FPU_OP_FEQ, `FPU_OP_FLT, `FPU_OP_FLE, `FPU_OP_FCLASS,
		`FPU_OP_FMV_TO_F, `FPU_OP_FMV_TO_X, 5'd0, 5'd2, 5'd5, 5'd16, 5'd29};

	// zeros, infinities, qNaN, sNaN, min subnormal, +1, -1, then edge values
	localparam logic [31:0] SPECIAL_S [16] = '{32'h00000000, 32'h80000000, 32'h7f800000,
		32'hff800000, 32'h7fc00000, 32'h7f800001, 32'h00000001, 32'h3f800000, 32'hbf800000,
		32'h80000001, 32'h7f7fffff, 32'hffc00000, 32'h7fbfffff, 32'h007fffff, 32'h00800000,
		32'h40000000};
	localparam logic [63:0] SPECIAL_D [16] = '{64'h0000000000000000, 64'h8000000000000000,
		64'h7ff0000000000000, 64'hfff0000000000000, 64'h7ff8000000000000,
		64'h7ff0000000000001, 64'h0000000000000001, 64'h3ff0000000000000,
		64'hbff0000000000000, 64'h8000000000000001, 64'h7fefffffffffffff,
		64'hfff8000000000000, 64'h7ff7ffffffffffff, 64'h000fffffffffffff,
		64'h0010000000000000, 64'h4000000000000000};

	logic               clk;
	logic               arst_n;
	logic               in_valid;
	fpu_pkg::fpu_req_t  req;
	logic               out_valid;
	fpu_pkg::fpu_resp_t resp;

	logic [31:0]        lfsr_state;
	int                 cycle_cnt = 0;
	fpu_pkg::fpu_resp_t exp_q [$]; // due one cycle after the strobe
	fpu_pkg::fpu_resp_t last_resp;

	fpu_misc_unit u_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.resp      (resp)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$fatal(1, "simulation timed out");
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v          = {v[62:0], lfsr_state[0]};
		end
	endtask

	task automatic draw_operand(input logic sgl, output fpu_pkg::fp_word_u w);
		logic [63:0] pick;
		logic [63:0] bits;
		draw(1, pick);
		if (pick[0]) begin
			draw(4, pick);
			draw(32, bits); // upper half of a single is don't-care
			w = sgl ? {bits[31:0], SPECIAL_S[pick[3:0]]} : SPECIAL_D[pick[3:0]];
		end else begin
			draw(64, bits);
			w = bits;
		end
	endtask

	task automatic build_request(output fpu_pkg::fpu_req_t r);
		logic [63:0]       v;
		fpu_pkg::fp_word_u w1;
		fpu_pkg::fp_word_u w2;
		r = '0;
		draw(4, v);
		r.ftype = FTYPE_TBL[v[3:0]];
		draw(2, v);
		r.fmt = v[1:0];
		draw_operand(r.fmt == `FPU_FMT_S, w1);
		draw_operand(r.fmt == `FPU_FMT_S, w2);
		draw(5, v);
		r.frs1   = w1;
		r.frs2   = w2;
		r.rd_idx = v[4:0];
	endtask

	function automatic logic sign_of(input logic [63:0] w, input logic sgl);
		return sgl ? w[31] : w[63];
	endfunction

	function automatic logic nan_of(input logic [63:0] w, input logic sgl);
		return sgl ? (&w[30:23] && |w[22:0]) : (&w[62:52] && |w[51:0]);
	endfunction

	function automatic logic snan_of(input logic [63:0] w, input logic sgl);
		return nan_of(w, sgl) && !(sgl ? w[22] : w[51]); // quiet bit clear
	endfunction

	// signed ordering key where both zeros map to 0
	function automatic longint key_of(input logic [63:0] w, input logic sgl);
		longint m;
		m = sgl ? longint'({33'b0, w[30:0]}) : longint'({1'b0, w[62:0]});
		return sign_of(w, sgl) ? -m : m;
	endfunction

	function automatic logic [9:0] fclass_of(input logic [63:0] w, input logic sgl);
		logic s;
		logic exp_zero;
		logic exp_ones;
		logic frac_zero;
		int   pos;
		s         = sign_of(w, sgl);
		exp_zero  = sgl ? ~|w[30:23] : ~|w[62:52];
		exp_ones  = sgl ? &w[30:23] : &w[62:52];
		frac_zero = sgl ? ~|w[22:0] : ~|w[51:0];
		if (exp_ones && !frac_zero)
			pos = snan_of(w, sgl) ? 8 : 9;
		else if (exp_ones)
			pos = s ? 0 : 7;
		else if (exp_zero && frac_zero)
			pos = s ? 3 : 4;
		else if (exp_zero)
			pos = s ? 2 : 5;
		else
			pos = s ? 1 : 6;
		return 10'b1 << pos;
	endfunction

	function automatic fpu_pkg::fpu_resp_t model_resp(input fpu_pkg::fpu_req_t r);
		fpu_pkg::fpu_resp_t e;
		logic               sgl;
		logic               is_min;
		logic               inj;
		logic [63:0]        a;
		logic [63:0]        b;
		logic               na;
		logic               nb;
		longint             ka;
		longint             kb;
		e        = '0;
		e.rd_idx = r.rd_idx;
		sgl      = r.fmt == `FPU_FMT_S;
		if (!sgl && r.fmt != `FPU_FMT_D)
			return e; // fmt 01 and 10 give nothing
		a      = sgl ? {32'b0, r.frs1[31:0]} : r.frs1;
		b      = sgl ? {32'b0, r.frs2[31:0]} : r.frs2;
		na     = nan_of(a, sgl);
		nb     = nan_of(b, sgl);
		ka     = key_of(a, sgl);
		kb     = key_of(b, sgl);
		is_min = r.ftype == `FPU_OP_FMIN;
		case (r.ftype)
			`FPU_OP_FMIN, `FPU_OP_FMAX: begin
				e.fflags_valid            = 1'b1;
				e.exception_flags.invalid = snan_of(a, sgl) | snan_of(b, sgl);
				if (na && nb)
					e.result = sgl ? {32'b0, `FPU_QNAN_S} : `FPU_QNAN_D;
				else if (na || nb)
					e.result = na ? b : a;
				else if (ka == kb)
					e.result = (sign_of(a, sgl) == is_min) ? a : b; // -0 below +0
				else
					e.result = ((ka < kb) == is_min) ? a : b;
			end
			`FPU_OP_FSGNJ, `FPU_OP_FSGNJN, `FPU_OP_FSGNJX: begin
				inj = sign_of(b, sgl);
				if (r.ftype == `FPU_OP_FSGNJN)
					inj = ~inj;
				else if (r.ftype == `FPU_OP_FSGNJX)
					inj = inj ^ sign_of(a, sgl);
				e.result = sgl ? {32'b0, inj, a[30:0]} : {inj, a[62:0]};
			end
			`FPU_OP_FEQ, `FPU_OP_FLT, `FPU_OP_FLE: begin
				e.fflags_valid            = 1'b1;
				e.exception_flags.invalid = na | nb; // flt/fle signal on any NaN
				if (r.ftype == `FPU_OP_FEQ) begin
					e.exception_flags.invalid = snan_of(a, sgl) | snan_of(b, sgl);
					e.result = {63'b0, !(na || nb) && ka == kb};
				end else if (r.ftype == `FPU_OP_FLT) begin
					e.result = {63'b0, !(na || nb) && ka < kb};
				end else begin
					e.result = {63'b0, !(na || nb) && ka <= kb};
				end
			end
			`FPU_OP_FCLASS:   e.result = {54'b0, fclass_of(a, sgl)};
			`FPU_OP_FMV_TO_F: e.result = a;
			`FPU_OP_FMV_TO_X: e.result = sgl ? {{32{a[31]}}, a[31:0]} : a;
			default:          e.result = '0;
		endcase
		return e;
	endfunction

	task automatic check_word(input string name, input fpu_pkg::fp_word_u got,
		input fpu_pkg::fp_word_u exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flags(input string name, input fpu_pkg::fpu_flags_t got,
		input fpu_pkg::fpu_flags_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic check_rd(input string name, input logic [`FPU_RFIDX_W-1:0] got,
		input logic [`FPU_RFIDX_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "register index mismatch");
		end
	endtask

	// outputs of the last posedge read at the falling edge
	task automatic check_outputs();
		fpu_pkg::fpu_resp_t e;
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			check_bit("out_valid", out_valid, 1'b1);
			check_word("resp.result", resp.result, e.result);
			check_flags("resp.exception_flags", resp.exception_flags, e.exception_flags);
			check_bit("resp.fflags_valid", resp.fflags_valid, e.fflags_valid);
			check_rd("resp.rd_idx", resp.rd_idx, e.rd_idx);
			last_resp = e;
		end else begin
			// no strobe so resp holds (zero after reset)
			check_bit("out_valid", out_valid, 1'b0);
			check_word("resp.result", resp.result, last_resp.result);
			check_flags("resp.exception_flags", resp.exception_flags,
				last_resp.exception_flags);
			check_bit("resp.fflags_valid", resp.fflags_valid, last_resp.fflags_valid);
			check_rd("resp.rd_idx", resp.rd_idx, last_resp.rd_idx);
		end
	endtask

	initial begin
		fpu_pkg::fpu_req_t r;
		logic [63:0]       v;
		clk        = 1'b0;
		arst_n     = 1'b0;
		in_valid   = 1'b0;
		req        = '0;
		lfsr_state = 32'h37f4;
		last_resp  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_outputs();
		for (int n = 0; n < NUM_REQ; n++) begin
			draw(2, v);
			if (v[1:0] == 2'b00) begin
				build_request(r); // junk on req while idle
				req      = r;
				in_valid = 1'b0;
				@(negedge clk);
				check_outputs();
			end
			build_request(r);
			req      = r;
			in_valid = 1'b1;
			exp_q.push_back(model_resp(r));
			@(negedge clk);
			check_outputs();
		end
		in_valid = 1'b0;
		@(negedge clk);
		check_outputs();
		if (exp_q.size() != 0) begin
			$display("%0d responses were never checked", exp_q.size());
			$display("Test failures found");
			$fatal(1, "run ended with pending responses");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

/* files.f */
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fp_classify.sv
hdl/fp_compare.sv
hdl/fp_result_select.sv
hdl/fpu_misc_unit.sv
tb/fpu_misc_asserts.sv
tb/tb_fpu_misc_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the misc fpu testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
	-f files.f \
	--top-module tb_fpu_misc_unit \
	--Mdir obj_dir \
	-o sim_fpu_misc

# a fatal stop exits nonzero, the verdict comes from the printed output
output=$(./obj_dir/sim_fpu_misc 2>&1) || true
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
